//--- src/fetch_pkg.sv
package fetch_pkg;

	// boot address, also used after wake-up
	localparam logic [31:0] RESET_PC  = 32'h4000_0000;

	// add x0, x0, x0
	localparam logic [31:0] NOP_INSTR = 32'h0000_0033;

	// L1.5 request encodings for an instruction fill
	localparam logic [4:0] RQ_IFILL   = 5'd0;
	localparam logic [2:0] IFILL_SIZE = 3'd4;   // word fetch

	// L1.5 return types this front end cares about
	localparam logic [3:0] RET_LOAD   = 4'b0000;
	localparam logic [3:0] RET_IFILL  = 4'b0001;
	localparam logic [3:0] RET_INT    = 4'b0111;   // wake-up interrupt
	localparam logic [3:0] RET_ST_ACK = 4'b0100;

	// next-pc choice from execute
	typedef enum logic [1:0] {
		PC_SEQ    = 2'd0,
		PC_RESET  = 2'd1,
		PC_TARGET = 2'd2,
		PC_HOLD   = 2'd3
	} pc_sel_e;

	// request channel toward the L1.5
	typedef struct packed {
		logic [4:0]  rqtype;
		logic [2:0]  size;
		logic [31:0] address;
		logic [31:0] data;      // unused for fills
		logic        val;
	} l15_req_t;

	// return channel from the L1.5, one full line
	typedef struct packed {
		logic        val;
		logic [3:0]  returntype;
		logic [31:0] data_0;
		logic [31:0] data_1;
		logic [31:0] data_2;
		logic [31:0] data_3;
	} l15_resp_t;

	// fetched pair handed to decode
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [31:0] instr;
	} fetch_out_t;

endpackage

//--- src/pc_gen.sv
`timescale 1ns/1ps

module pc_gen (
	input  logic               clk,
	input  logic               nrst,
	input  fetch_pkg::pc_sel_e pcsel,
	input  logic [31:0]        target,
	input  logic               awake,
	input  logic               advance,
	output logic [31:0]        pc,
	output logic               redirect
);
	import fetch_pkg::*;

	logic        awake_q;   // awake delayed by one cycle
	logic        wake;      // first cycle after the interrupt return
	logic        live;
	logic [31:0] pc_d;

	assign wake = awake && !awake_q;
	assign live = awake && awake_q;

	// control flow changes only count once the core runs
	assign redirect = live && (pcsel == PC_TARGET || pcsel == PC_RESET);

	always_comb
	begin
		pc_d = pc;
		if (wake)
		begin
			pc_d = RESET_PC;   // restart the program
		end
		else if (live)
		begin
			case (pcsel)
				PC_SEQ:
				begin
					// step only once the current pair has gone to decode
					if (advance)
						pc_d = pc + 32'd4;
				end
				PC_RESET:
				begin
					pc_d = RESET_PC;
				end
				PC_TARGET:
				begin
					pc_d = target;
				end
				PC_HOLD:
				begin
					pc_d = pc;
				end
				default:
				begin
					pc_d = pc;
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			pc      <= RESET_PC;
			awake_q <= 1'b0;
		end
		else
		begin
			pc      <= pc_d;
			awake_q <= awake;
		end
	end

endmodule

//--- src/l15_fetch_port.sv
`timescale 1ns/1ps

module l15_fetch_port (
	input  logic                 clk,
	input  logic                 nrst,
	input  logic [31:0]          pc,
	input  logic                 slot_free,
	input  logic                 ack,
	input  logic                 header_ack,
	input  fetch_pkg::l15_resp_t l15_resp,
	output fetch_pkg::l15_req_t  l15_req,
	output logic                 req_ack,
	output logic                 awake,
	output logic                 issue,
	output logic [31:0]          issue_addr,
	output logic                 instr_strobe,
	output logic [31:0]          instr_word
);
	import fetch_pkg::*;

	typedef enum logic [1:0] {
		ST_REQ  = 2'd0,
		ST_WAIT = 2'd1,
		ST_RESP = 2'd2
	} port_state_e;

	port_state_e state_q;
	port_state_e state_d;
	logic        req_val_q;
	logic        req_val_d;
	logic        req_ack_q;
	logic        awake_q;
	logic [31:0] word_q;
	logic        resp_new;   // return not yet acknowledged
	logic        fill_hit;
	logic        int_hit;
	logic        fire;

	// the return is still up during its ack cycle, so skip that cycle
	assign resp_new = l15_resp.val && !req_ack_q;

	assign fill_hit = (state_q == ST_WAIT) && resp_new
		&& (l15_resp.returntype == RET_IFILL || l15_resp.returntype == RET_LOAD);

	assign int_hit = resp_new && (l15_resp.returntype == RET_INT);

	// request leaves when both acks are seen together
	assign fire = req_val_q && ack && header_ack;

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			ST_REQ:
			begin
				if (fire)
					state_d = ST_WAIT;
			end
			ST_WAIT:
			begin
				if (fill_hit)
					state_d = ST_RESP;
			end
			ST_RESP:
			begin
				state_d = ST_REQ;   // single cycle strobe to the merger
			end
			default:
			begin
				state_d = ST_REQ;
			end
		endcase
	end

	always_comb
	begin
		if (req_val_q)
			req_val_d = !fire;   // hold until accepted
		else
			req_val_d = (state_q == ST_REQ) && awake_q && slot_free;
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state_q   <= ST_REQ;
			req_val_q <= 1'b0;
			req_ack_q <= 1'b0;
			awake_q   <= 1'b0;
		end
		else
		begin
			state_q   <= state_d;
			req_val_q <= req_val_d;
			req_ack_q <= resp_new;   // every return gets one ack
			if (int_hit)
				awake_q <= 1'b1;     // sticky until reset
		end
	end

	// only word 0 of the line is kept
	always_ff @(posedge clk)
	begin
		if (fill_hit)
			word_q <= l15_resp.data_0;
	end

	always_comb
	begin
		l15_req.rqtype  = RQ_IFILL;
		l15_req.size    = IFILL_SIZE;
		l15_req.address = pc;
		l15_req.data    = 32'd0;
		l15_req.val     = req_val_q;
	end

	assign req_ack      = req_ack_q;
	assign awake        = awake_q;
	assign issue        = fire;
	assign issue_addr   = pc;
	assign instr_strobe = (state_q == ST_RESP);
	assign instr_word   = word_q;

endmodule

//--- src/fetch_merge.sv
`timescale 1ns/1ps

module fetch_merge (
	input  logic                  clk,
	input  logic                  nrst,
	input  logic                  stall,
	input  logic                  redirect,
	input  logic                  issue,
	input  logic [31:0]           issue_addr,
	input  logic                  instr_strobe,
	input  logic [31:0]           instr_word,
	output logic                  slot_free,
	output logic                  advance,
	output fetch_pkg::fetch_out_t fetch_out
);
	import fetch_pkg::*;

	fetch_out_t  out_q;
	logic        busy_q;       // fetch outstanding on the L1.5
	logic        kill_q;       // outstanding fetch is on the wrong path
	logic [31:0] fetch_pc_q;
	logic        killed;
	logic        consume;

	// a redirect in the return cycle also drops the word
	assign killed  = kill_q || redirect;
	assign consume = out_q.valid && !stall;   // decode takes the pair

	assign slot_free = !out_q.valid && !busy_q;
	assign advance   = consume;
	assign fetch_out = out_q;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			busy_q <= 1'b0;
			kill_q <= 1'b0;
			out_q  <= '{valid: 1'b0, pc: RESET_PC, instr: NOP_INSTR};
		end
		else
		begin
			if (issue)
			begin
				busy_q <= 1'b1;
				kill_q <= redirect;   // address went out before the pc moved
			end
			else if (instr_strobe)
			begin
				busy_q <= 1'b0;
				kill_q <= 1'b0;
			end
			else if (busy_q && redirect)
			begin
				kill_q <= 1'b1;
			end

			if (instr_strobe && !killed)
				out_q <= '{valid: 1'b1, pc: fetch_pc_q, instr: instr_word};
			else if (redirect || !stall)
				out_q <= '{valid: 1'b0, pc: out_q.pc, instr: NOP_INSTR};
		end
	end

	always_ff @(posedge clk)
	begin
		if (issue)
			fetch_pc_q <= issue_addr;
	end

endmodule

//--- src/fetch_frontend.sv
`timescale 1ns/1ps

module fetch_frontend (
	input  logic                  clk,
	input  logic                  nrst,
	input  logic                  stall,
	input  fetch_pkg::pc_sel_e    pcsel,
	input  logic [31:0]           target,
	input  logic                  ack,
	input  logic                  header_ack,
	input  fetch_pkg::l15_resp_t  l15_resp,
	output fetch_pkg::l15_req_t   l15_req,
	output logic                  req_ack,
	output fetch_pkg::fetch_out_t fetch_out
);

	logic [31:0] pc;
	logic        redirect;
	logic        awake;
	logic        issue;
	logic [31:0] issue_addr;
	logic        instr_strobe;
	logic [31:0] instr_word;
	logic        slot_free;
	logic        advance;

	pc_gen u_pc_gen (
		.clk      (clk),
		.nrst     (nrst),
		.pcsel    (pcsel),
		.target   (target),
		.awake    (awake),
		.advance  (advance),
		.pc       (pc),
		.redirect (redirect)
	);

	// single outstanding fill on the L1.5 port
	l15_fetch_port u_l15_fetch_port (
		.clk          (clk),
		.nrst         (nrst),
		.pc           (pc),
		.slot_free    (slot_free),
		.ack          (ack),
		.header_ack   (header_ack),
		.l15_resp     (l15_resp),
		.l15_req      (l15_req),
		.req_ack      (req_ack),
		.awake        (awake),
		.issue        (issue),
		.issue_addr   (issue_addr),
		.instr_strobe (instr_strobe),
		.instr_word   (instr_word)
	);

	fetch_merge u_fetch_merge (
		.clk          (clk),
		.nrst         (nrst),
		.stall        (stall),
		.redirect     (redirect),
		.issue        (issue),
		.issue_addr   (issue_addr),
		.instr_strobe (instr_strobe),
		.instr_word   (instr_word),
		.slot_free    (slot_free),
		.advance      (advance),
		.fetch_out    (fetch_out)
	);

endmodule

//--- dv/l15_model.sv
`timescale 1ns/1ps

module l15_model (
	input  logic                 clk,
	input  logic                 nrst,
	input  fetch_pkg::l15_req_t  l15_req,
	input  logic                 req_ack,
	output logic                 ack,
	output logic                 header_ack,
	output fetch_pkg::l15_resp_t l15_resp
);
	import fetch_pkg::*;

	integer      seed = 32'hf9d5;
	logic        ack_q = 1'b0;
	l15_resp_t   resp_q = '0;
	logic        pend;         // fill accepted, return not yet sent
	logic [31:0] pend_addr;
	logic [2:0]  delay;
	logic [3:0]  boot_cnt;     // idle cycles before the wake-up return
	logic        int_sent;

	assign ack        = ack_q;
	assign header_ack = ack_q;
	assign l15_resp   = resp_q;

	always @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			ack_q     <= 1'b0;
			resp_q    <= '0;
			pend      <= 1'b0;
			pend_addr <= 32'd0;
			delay     <= 3'd0;
			boot_cnt  <= 4'd0;
			int_sent  <= 1'b0;
		end
		else
		begin
			if (ack_q && l15_req.val)
			begin
				ack_q     <= 1'b0;   // request taken this cycle
				pend      <= 1'b1;
				pend_addr <= l15_req.address;
				delay     <= 3'($random(seed));
			end
			else
				ack_q <= l15_req.val && (($random(seed) & 1) != 0);

			// one return on the channel at a time, held until req_ack
			if (resp_q.val)
			begin
				if (req_ack)
					resp_q.val <= 1'b0;
			end
			else if (!int_sent)
			begin
				boot_cnt <= boot_cnt + 4'd1;
				if (boot_cnt == 4'd8)
				begin
					resp_q   <= '{1'b1, RET_INT, 32'd0, 32'd0, 32'd0, 32'd0};
					int_sent <= 1'b1;
				end
			end
			else if (pend && delay == 3'd0)
			begin
				resp_q <= '{1'b1, RET_IFILL, pend_addr ^ 32'h1357_9bdf, 32'd0, 32'd0, 32'd0};
				pend   <= 1'b0;
			end
			else if (pend && ($random(seed) & 3) == 0)
				resp_q <= '{1'b1, RET_ST_ACK, 32'd0, 32'd0, 32'd0, 32'd0};   // unsolicited

			if (pend && delay != 3'd0)
				delay <= delay - 3'd1;
		end
	end

endmodule

//--- dv/tb_fetch_frontend.sv
`timescale 1ns/1ps

module tb_fetch_frontend;
	import fetch_pkg::*;

	logic        clk;
	logic        nrst;
	logic        stall;
	pc_sel_e     pcsel;
	logic [31:0] target;
	logic        ack;
	logic        header_ack;
	l15_resp_t   l15_resp;
	l15_req_t    l15_req;
	logic        req_ack;
	fetch_out_t  fetch_out;

	integer      seed;
	integer      err [1:6] = '{0, 0, 0, 0, 0, 0};
	integer      st_acks;
	integer      issues;
	logic        int_seen;
	logic        redir_pend;   // redirect since the last delivery
	logic        wrong_path;   // outstanding fetch is to be dropped
	logic [31:0] exp_pc;
	logic        issue;
	logic        consume;
	logic        ret_new;
	logic        fill_new;

	assign issue    = l15_req.val && ack && header_ack;
	assign consume  = fetch_out.valid && !stall;
	assign ret_new  = l15_resp.val && !req_ack;
	assign fill_new = ret_new && l15_resp.returntype == RET_IFILL;

	fetch_frontend DUT (.*);
	l15_model u_l15_model (.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] expected_instr(input logic [31:0] addr);
		return addr ^ 32'h1357_9bdf;
	endfunction

	task automatic report_mismatch(input integer t, input string name,
		input logic [31:0] exp_val, input logic [31:0] act_val);
		err[t] = err[t] + 1;
		$display("MISMATCH %s expected %08h actual %08h at %0t", name, exp_val, act_val, $time);
	endtask

	task automatic report_fault(input integer t, input string what);
		err[t] = err[t] + 1;
		$display("ERROR test %0d: %s at %0t", t, what, $time);
	endtask

	task automatic show_result(input integer t, input string name);
		$display("test %s finished with %0d errors", name, err[t]);
	endtask

	task automatic abort_run(input string what);
		$display("timeout waiting for %s", what);
		$display("Checks failed");
		$finish;
	endtask

	task automatic wait_deliveries(input integer n, input integer limit, input string what);
		integer seen;
		integer cycles;
		seen   = 0;
		cycles = 0;
		while (seen < n && cycles <= limit)
		begin
			@(posedge clk);
			if (consume)
				seen++;
			cycles++;
		end
		if (seen < n)
			abort_run(what);
	endtask

	task automatic run_stalled(input integer n, input integer limit);
		integer seen;
		integer cycles;
		seen   = 0;
		cycles = 0;
		while (seen < n && cycles <= limit)
		begin
			@(posedge clk);
			if (consume)
				seen++;
			stall <= ($random(seed) & 1) != 0;   // decode back-pressure
			cycles++;
		end
		stall <= 1'b0;
		if (seen < n)
			abort_run("fetches under random stall");
	endtask

	// reference state, updated from the same edges the DUT sees
	always @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			int_seen   <= 1'b0;
			st_acks    <= 0;
			issues     <= 0;
			wrong_path <= 1'b0;
			redir_pend <= 1'b0;
			exp_pc     <= RESET_PC;
		end
		else
		begin
			if (ret_new && l15_resp.returntype == RET_INT)
				int_seen <= 1'b1;
			if (ret_new && l15_resp.returntype == RET_ST_ACK)
				st_acks <= st_acks + 1;
			if (issue)
			begin
				issues     <= issues + 1;
				wrong_path <= (pcsel == PC_TARGET);   // address left before the pc moved
			end
			else if (pcsel == PC_TARGET)
				wrong_path <= 1'b1;
			if (pcsel == PC_TARGET)
			begin
				exp_pc     <= target;
				redir_pend <= 1'b1;
			end
			else if (consume)
			begin
				exp_pc     <= exp_pc + 32'd4;
				redir_pend <= 1'b0;
			end
		end
	end

	assert property (@(posedge clk) disable iff (!nrst)
		!int_seen |-> !l15_req.val && !req_ack && !fetch_out.valid)
		else report_fault(1, "request, ack or valid seen before the wake-up return");
	assert property (@(posedge clk) disable iff (!nrst)
		issue && issues == 0 |-> l15_req.address == RESET_PC)
		else report_mismatch(1, "reset_sleep", RESET_PC, $sampled(l15_req.address));

	// decode sees a no-op whenever nothing is ready
	assert property (@(posedge clk) disable iff (!nrst)
		!fetch_out.valid |-> fetch_out.instr == NOP_INSTR)
		else report_mismatch(1, "reset_sleep", NOP_INSTR, $sampled(fetch_out.instr));

	assert property (@(posedge clk) disable iff (!nrst)
		fetch_out.valid |-> fetch_out.instr == expected_instr(fetch_out.pc))
		else report_mismatch(2, "sequential", expected_instr($sampled(fetch_out.pc)),
			$sampled(fetch_out.instr));
	assert property (@(posedge clk) disable iff (!nrst)
		consume && !redir_pend |-> fetch_out.pc == exp_pc)
		else report_mismatch(2, "sequential", $sampled(exp_pc), $sampled(fetch_out.pc));

	// word fill request, type and size packed into one word
	assert property (@(posedge clk) disable iff (!nrst)
		l15_req.val |-> l15_req.rqtype == RQ_IFILL && l15_req.size == IFILL_SIZE)
		else report_mismatch(2, "sequential", {24'd0, RQ_IFILL, IFILL_SIZE},
			{24'd0, $sampled(l15_req.rqtype), $sampled(l15_req.size)});
	assert property (@(posedge clk) disable iff (!nrst)
		l15_req.val |-> l15_req.data == 32'd0)
		else report_mismatch(2, "sequential", 32'd0, $sampled(l15_req.data));

	// killed fetches would show up here as a pc other than the target
	assert property (@(posedge clk) disable iff (!nrst)
		consume && redir_pend |-> fetch_out.pc == exp_pc)
		else report_mismatch(3, "redirect", $sampled(exp_pc), $sampled(fetch_out.pc));

	assert property (@(posedge clk) disable iff (!nrst)
		$past(stall && fetch_out.valid && pcsel != PC_TARGET) |-> fetch_out == $past(fetch_out))
		else report_fault(4, "decode output changed while stalled");
	assert property (@(posedge clk) disable iff (!nrst)
		$past(stall && fetch_out.valid) |-> !$rose(l15_req.val))
		else report_fault(4, "new request raised while stalled");

	assert property (@(posedge clk) disable iff (!nrst)
		$past(l15_resp.val && !req_ack) |-> req_ack)
		else report_fault(5, "return left without a req_ack pulse");
	assert property (@(posedge clk) disable iff (!nrst)
		$past(req_ack) |-> !req_ack)
		else report_fault(5, "req_ack held longer than one cycle");
	assert property (@(posedge clk) disable iff (!nrst)
		$rose(fetch_out.valid) |-> $past(fill_new, 2))
		else report_fault(5, "valid fetch without a fill return two cycles before");

	assert property (@(posedge clk) disable iff (!nrst)
		$past(fill_new && !wrong_path && pcsel != PC_TARGET, 2) && $past(pcsel != PC_TARGET)
		|-> fetch_out.valid)
		else report_mismatch(6, "latency", 32'd1, {31'd0, $sampled(fetch_out.valid)});

	initial
	begin
		integer i;
		integer gap;
		integer total;
		seed   = 32'hf9d5;
		nrst   <= 1'b0;
		stall  <= 1'b0;
		pcsel  <= PC_SEQ;
		target <= 32'd0;
		repeat (10) @(posedge clk);
		nrst <= 1'b1;

		wait_deliveries(1, 300, "the first fetch after wake-up");
		show_result(1, "reset_sleep");
		wait_deliveries(8, 400, "sequential fetches");
		show_result(2, "sequential");

		// land redirects at different points of a fetch
		for (i = 0; i < 4; i++)
		begin
			gap = $random(seed) & 7;
			repeat (gap) @(posedge clk);
			pcsel  <= PC_TARGET;
			target <= RESET_PC + 32'h2000 + 32'(i) * 32'h100;
			@(posedge clk);
			pcsel <= PC_SEQ;
			wait_deliveries(3, 300, "fetches after a redirect");
		end
		show_result(3, "redirect");

		run_stalled(12, 800);
		show_result(4, "stall");
		repeat (20) @(posedge clk);
		if (st_acks == 0)
			report_fault(5, "no store ack return was seen");
		show_result(5, "unsolicited");
		show_result(6, "latency");

		total = 0;
		for (i = 1; i <= 6; i++)
			total = total + err[i];
		$display("tests 6, errors %0d, store acks %0d", total, st_acks);
		if (total == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- fetch_frontend.f
src/fetch_pkg.sv
src/pc_gen.sv
src/l15_fetch_port.sv
src/fetch_merge.sv
src/fetch_frontend.sv
dv/l15_model.sv
dv/tb_fetch_frontend.sv

//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --top-module fetch_frontend \
		src/fetch_pkg.sv src/pc_gen.sv src/l15_fetch_port.sv \
		src/fetch_merge.sv src/fetch_frontend.sv

sim:
	verilator --binary --timing --assert --top-module tb_fetch_frontend \
		-f fetch_frontend.f -o tb_sim
	./obj_dir/tb_sim > sim.log 2>&1; cat sim.log
	@if grep -q "Checks failed" sim.log; then exit 1; fi
	@grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
